// ==== cpu_backend.f ====
hdl/cpu_pkg.sv
hdl/alu.sv
hdl/data_ram.sv
hdl/exe_stage.sv
hdl/mem_stage.sv
hdl/wb_stage.sv
hdl/cpu_backend.sv
bench/cpu_backend_tb.sv

// ==== Makefile ====
# Verilator build for the pipeline back end.

VERILATOR ?= verilator
TOP       ?= cpu_backend_tb
FLAGS     ?= --binary --timing --timescale 1ns/1ps
FILELIST  := cpu_backend.f
OBJ_DIR   := obj_dir
SIM       := $(OBJ_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# the output is shown and searched in one pass, so a missing pass line fails make.
run: compile
	./$(SIM) | tee /dev/stderr | grep "Simulation passed" > /dev/null

clean:
	rm -rf $(OBJ_DIR)

// ==== bench/cpu_backend_tb.sv ====
`default_nettype none

module cpu_backend_tb;

    timeunit 1ns;
    timeprecision 1ps;

    localparam int ALU_OPS        = 12 * 20;
    localparam int SEL_OPS        = 36;
    localparam int MEM_OPS        = 24 + 24 + 32 + 16;
    localparam int STREAM_OPS     = 200 + 3;
    localparam int TIMEOUT_CYCLES = 20 * (ALU_OPS + SEL_OPS + MEM_OPS + STREAM_OPS) + 200;

    logic               clk;
    logic               reset;
    logic               in_valid;
    cpu_pkg::ds_to_es_t in_bus;
    logic               in_allowin;
    logic               wb_valid;
    logic               wb_ready;
    cpu_pkg::wb_rec_t   wb;

    int                 seed = 32'hf7db;
    int                 ready_seed = 32'hf7db;    // the ready pattern keeps its own copy.
    int                 ready_mode;               // 0 low, 1 high, 2 random.
    int                 cycle_count;
    int                 error_count;
    int                 test_errors;
    int                 tests_passed;
    int                 tests_failed;
    int                 checked;
    logic [31:0]        pc_next;
    logic [31:0]        model_mem [cpu_pkg::DATA_RAM_WORDS];
    logic [31:0]        stored_addr [$];
    cpu_pkg::wb_rec_t   expected_q [$];

    cpu_backend dut0 (
        .clk        (clk),
        .reset      (reset),
        .in_valid   (in_valid),
        .in_bus     (in_bus),
        .in_allowin (in_allowin),
        .wb_valid   (wb_valid),
        .wb_ready   (wb_ready),
        .wb         (wb)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    function automatic logic [31:0] rand32();
        return $random(seed);
    endfunction

    function automatic logic [cpu_pkg::DATA_RAM_AW-1:0] word_index(logic [31:0] addr);
        return addr[cpu_pkg::DATA_RAM_AW+1:2];
    endfunction

    function automatic logic [31:0] ref_alu(cpu_pkg::alu_op_t op, logic [31:0] a, logic [31:0] b);
        logic [63:0] ext;
        case (op)
            cpu_pkg::ADD:  return a + b;
            cpu_pkg::SUB:  return a + ~b + 32'd1;
            cpu_pkg::SLT:  return (a[31] != b[31]) ? {31'b0, a[31]} : {31'b0, a < b};
            cpu_pkg::SLTU: return {31'b0, a < b};
            cpu_pkg::AND:  return a & b;
            cpu_pkg::OR:   return a | b;
            cpu_pkg::XOR:  return a ^ b;
            cpu_pkg::NOR:  return ~a & ~b;
            cpu_pkg::SLL:  return b << a[4:0];
            cpu_pkg::SRL:  return b >> a[4:0];
            cpu_pkg::SRA: begin
                ext = {{32{b[31]}}, b} >> a[4:0];
                return ext[31:0];
            end
            cpu_pkg::LUI:  return {b[15:0], 16'h0000};
            default:       return 32'h0;
        endcase
    endfunction

    // expected retire record, read against the model memory at issue time.
    function automatic cpu_pkg::wb_rec_t ref_record(cpu_pkg::ds_to_es_t op);
        cpu_pkg::wb_rec_t rec;
        logic [31:0]      a;
        logic [31:0]      b;
        logic [31:0]      res;
        a = op.src1_is_sa ? {27'b0, op.imm[10:6]} : (op.src1_is_pc ? op.pc : op.rs_value);
        b = op.src2_is_imm ? {{16{op.imm[15]}}, op.imm} : (op.src2_is_8 ? 32'd8 : op.rt_value);
        res = ref_alu(op.alu_op, a, b);
        rec.we = op.gr_we;
        rec.dest = op.dest;
        rec.data = op.load_op ? model_mem[word_index(res)] : res;
        rec.pc = op.pc;
        return rec;
    endfunction

    function automatic cpu_pkg::alu_op_t random_kind();
        int k;
        k = rand32() % 12;
        return cpu_pkg::alu_op_t'(k[3:0]);
    endfunction

    function automatic cpu_pkg::ds_to_es_t alu_op_rand(cpu_pkg::alu_op_t kind);
        cpu_pkg::ds_to_es_t op;
        logic [31:0]        r;
        r = rand32();
        op = '0;
        op.alu_op = kind;
        op.gr_we = 1'b1;
        op.dest = r[4:0];
        op.imm = r[20:5];
        op.rs_value = rand32();
        op.rt_value = rand32();
        return op;
    endfunction

    function automatic cpu_pkg::ds_to_es_t select_operands(cpu_pkg::ds_to_es_t op, int s1, int s2);
        op.src1_is_sa = (s1 == 1);
        op.src1_is_pc = (s1 == 2);
        op.src2_is_imm = (s2 == 1);
        op.src2_is_8 = (s2 == 2);
        return op;
    endfunction

    // base plus a random aligned offset that lands on addr.
    function automatic cpu_pkg::ds_to_es_t address_op(logic [31:0] addr);
        cpu_pkg::ds_to_es_t op;
        logic [31:0]        r;
        r = rand32();
        op = '0;
        op.alu_op = cpu_pkg::ADD;
        op.src2_is_imm = 1'b1;
        op.dest = r[20:16];
        op.imm = {r[15:2], 2'b00};
        op.rs_value = addr - {{16{op.imm[15]}}, op.imm};
        op.rt_value = rand32();
        return op;
    endfunction

    function automatic cpu_pkg::ds_to_es_t make_store(logic [31:0] addr, logic [31:0] data);
        cpu_pkg::ds_to_es_t op;
        op = address_op(addr);
        op.mem_we = 1'b1;
        op.rt_value = data;
        return op;
    endfunction

    function automatic cpu_pkg::ds_to_es_t make_load(logic [31:0] addr);
        cpu_pkg::ds_to_es_t op;
        op = address_op(addr);
        op.load_op = 1'b1;
        op.gr_we = 1'b1;
        return op;
    endfunction

    function automatic logic [31:0] pick_stored();
        logic [31:0] r;
        r = rand32();
        return stored_addr[r % stored_addr.size()];
    endfunction

    function automatic cpu_pkg::ds_to_es_t random_op();
        logic [31:0] r;
        int          k;
        r = rand32();
        k = r % 6;
        if (k == 0) begin
            return make_store(rand32(), rand32());
        end
        if (k == 1) begin
            return make_load(pick_stored());
        end
        return select_operands(alu_op_rand(random_kind()), int'(r[9:8]) % 3, int'(r[11:10]) % 3);
    endfunction

    task automatic record_issue(input cpu_pkg::ds_to_es_t op);
        expected_q.push_back(ref_record(op));
        if (op.mem_we) begin
            model_mem[word_index(ref_alu(op.alu_op, op.rs_value, {{16{op.imm[15]}}, op.imm}))] =
                op.rt_value;
        end
        pc_next += 4;
    endtask

    task automatic issue_op(input cpu_pkg::ds_to_es_t op);
        @(negedge clk);
        op.pc = pc_next;
        in_valid = 1'b1;
        in_bus = op;
        @(posedge clk);
        while (!in_allowin) begin
            @(posedge clk);
        end
        record_issue(op);
    endtask

    task automatic finish_test(input string name);
        @(negedge clk);
        in_valid = 1'b0;
        while (expected_q.size() != 0) begin
            @(posedge clk);
        end
        if (error_count == test_errors) begin
            tests_passed++;
            $display("test %s: ok, %0d records checked so far", name, checked);
        end else begin
            tests_failed++;
            $display("test %s: %0d errors", name, error_count - test_errors);
        end
        test_errors = error_count;
    endtask

    // with wb_ready held low the chain takes exactly three operations.
    task automatic check_fill();
        cpu_pkg::ds_to_es_t op;
        int                 accepted;
        accepted = 0;
        ready_mode = 0;
        op = random_op();
        repeat (8) begin
            @(negedge clk);
            op.pc = pc_next;
            in_valid = 1'b1;
            in_bus = op;
            @(posedge clk);
            if (in_allowin) begin
                record_issue(op);
                accepted++;
                op = random_op();
            end
        end
        @(negedge clk);
        in_valid = 1'b0;
        if (accepted != 3) begin
            $display("stalled pipeline accepted %0d operations instead of 3", accepted);
            error_count++;
        end
        if (in_allowin !== 1'b0) begin
            $display("** Error in_allowin = 0x%h, expected 0x0", in_allowin);
            error_count++;
        end
        ready_mode = 1;
    endtask

    initial begin
        logic [31:0] r;
        wb_ready = 1'b0;
        forever begin
            @(negedge clk);
            r = $random(ready_seed);
            if (ready_mode == 2) begin
                wb_ready = r[0];
            end else begin
                wb_ready = (ready_mode == 1);
            end
        end
    end

    initial begin
        cpu_pkg::wb_rec_t exp_rec;
        forever begin
            @(posedge clk);
            if (wb_valid && wb_ready) begin
                if (expected_q.size() == 0) begin
                    $display("unexpected retire record at pc 0x%h with nothing outstanding", wb.pc);
                    error_count++;
                end else begin
                    exp_rec = expected_q.pop_front();
                    checked++;
                    if (wb.we !== exp_rec.we) begin
                        $display("** Error wb.we = 0x%h, expected 0x%h", wb.we, exp_rec.we);
                        error_count++;
                    end
                    if (wb.dest !== exp_rec.dest) begin
                        $display("** Error wb.dest = 0x%h, expected 0x%h", wb.dest, exp_rec.dest);
                        error_count++;
                    end
                    if (wb.data !== exp_rec.data) begin
                        $display("** Error wb.data = 0x%h, expected 0x%h (pc 0x%h)",
                                 wb.data, exp_rec.data, exp_rec.pc);
                        error_count++;
                    end
                    if (wb.pc !== exp_rec.pc) begin
                        $display("** Error wb.pc = 0x%h, expected 0x%h", wb.pc, exp_rec.pc);
                        error_count++;
                    end
                end
            end
        end
    end

    initial begin
        cycle_count = 0;
        while (cycle_count < TIMEOUT_CYCLES) begin
            @(posedge clk);
            cycle_count++;
        end
        $display("timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
        $display("Simulation failed");
        $finish;
    end

    initial begin
        cpu_pkg::ds_to_es_t op;
        logic [31:0]        addr;
        reset = 1'b1;
        in_valid = 1'b0;
        in_bus = '0;
        ready_mode = 1;
        pc_next = 32'h0040_0000;
        error_count = 0;
        test_errors = 0;
        tests_passed = 0;
        tests_failed = 0;
        checked = 0;
        repeat (16) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;

        repeat (10) begin
            @(negedge clk);
            if (wb_valid !== 1'b0) begin
                $display("** Error wb_valid = 0x%h, expected 0x0", wb_valid);
                error_count++;
            end
            if (in_allowin !== 1'b1) begin
                $display("** Error in_allowin = 0x%h, expected 0x1", in_allowin);
                error_count++;
            end
        end
        finish_test("reset_state");

        for (int k = 0; k < 12; k++) begin
            for (int i = 0; i < 20; i++) begin
                issue_op(alu_op_rand(cpu_pkg::alu_op_t'(k[3:0])));
            end
        end
        finish_test("alu_ops");

        for (int i = 0; i < SEL_OPS; i++) begin
            op = select_operands(alu_op_rand(random_kind()), i % 3, (i / 3) % 3);
            op.imm[15] = i[0];    // every other immediate is negative.
            issue_op(op);
        end
        finish_test("operand_select");

        for (int i = 0; i < 24; i++) begin
            addr = rand32();
            stored_addr.push_back(addr);
            issue_op(make_store(addr, rand32()));
        end
        for (int i = 0; i < 24; i++) begin
            issue_op(make_load(pick_stored()));
        end
        for (int i = 0; i < 16; i++) begin
            issue_op(make_store(pick_stored(), rand32()));
            issue_op(make_load(pick_stored()));
        end
        for (int i = 0; i < 8; i++) begin
            addr = pick_stored();
            issue_op(make_store(addr, rand32()));
            issue_op(make_load(addr));
        end
        finish_test("load_store");

        ready_mode = 2;
        for (int i = 0; i < 200; i++) begin
            issue_op(random_op());
        end
        @(negedge clk);
        in_valid = 1'b0;
        ready_mode = 1;
        while (expected_q.size() != 0) begin
            @(posedge clk);
        end
        check_fill();
        finish_test("back_pressure");

        $display("tests passed %0d, tests failed %0d, records checked %0d, errors %0d",
                 tests_passed, tests_failed, checked, error_count);
        if (error_count == 0 && tests_failed == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== hdl/cpu_backend.sv ====
`default_nettype none

module cpu_backend (
    input  wire logic              clk,
    input  wire logic              reset,
    input  wire logic              in_valid,
    input  var cpu_pkg::ds_to_es_t in_bus,
    output logic                   in_allowin,
    output logic                   wb_valid,
    input  wire logic              wb_ready,
    output cpu_pkg::wb_rec_t       wb
);

    logic               es_to_ms_valid;
    logic               ms_allowin;
    cpu_pkg::es_to_ms_t es_to_ms_bus;
    logic               ms_to_ws_valid;
    logic               ws_allowin;
    cpu_pkg::ms_to_ws_t ms_to_ws_bus;
    logic               ram_en;
    logic [3:0]         ram_wen;
    logic [31:0]        ram_addr;
    logic [31:0]        ram_wdata;
    logic [31:0]        ram_rdata;

    exe_stage u_exe_stage (
        .clk            (clk),
        .reset          (reset),
        .in_valid       (in_valid),
        .in_bus         (in_bus),
        .in_allowin     (in_allowin),
        .ms_allowin     (ms_allowin),
        .es_to_ms_valid (es_to_ms_valid),
        .es_to_ms_bus   (es_to_ms_bus),
        .ram_en         (ram_en),
        .ram_wen        (ram_wen),
        .ram_addr       (ram_addr),
        .ram_wdata      (ram_wdata)
    );

    mem_stage u_mem_stage (
        .clk            (clk),
        .reset          (reset),
        .es_to_ms_valid (es_to_ms_valid),
        .es_to_ms_bus   (es_to_ms_bus),
        .ms_allowin     (ms_allowin),
        .ram_rdata      (ram_rdata),
        .ws_allowin     (ws_allowin),
        .ms_to_ws_valid (ms_to_ws_valid),
        .ms_to_ws_bus   (ms_to_ws_bus)
    );

    wb_stage u_wb_stage (
        .clk            (clk),
        .reset          (reset),
        .ms_to_ws_valid (ms_to_ws_valid),
        .ms_to_ws_bus   (ms_to_ws_bus),
        .ws_allowin     (ws_allowin),
        .wb_valid       (wb_valid),
        .wb_ready       (wb_ready),
        .wb             (wb)
    );

    data_ram u_data_ram (
        .clk   (clk),
        .en    (ram_en),
        .wen   (ram_wen),
        .addr  (ram_addr),
        .wdata (ram_wdata),
        .rdata (ram_rdata)
    );

endmodule

`default_nettype wire

// ==== hdl/wb_stage.sv ====
`default_nettype none

module wb_stage (
    input  wire logic              clk,
    input  wire logic              reset,
    input  wire logic              ms_to_ws_valid,
    input  var cpu_pkg::ms_to_ws_t ms_to_ws_bus,
    output logic                   ws_allowin,
    output logic                   wb_valid,
    input  wire logic              wb_ready,
    output cpu_pkg::wb_rec_t       wb
);

    logic               ws_valid;
    cpu_pkg::ms_to_ws_t ws_bus;

    assign ws_allowin = !ws_valid || wb_ready;    // record leaves once the consumer takes it.
    assign wb_valid   = ws_valid;

    always_ff @(posedge clk) begin
        if (reset) begin
            ws_valid <= 1'b0;
        end else if (ws_allowin) begin
            ws_valid <= ms_to_ws_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (ms_to_ws_valid && ws_allowin) begin
            ws_bus <= ms_to_ws_bus;
        end
    end

    assign wb.we   = ws_bus.gr_we;    // stores retire with we low.
    assign wb.dest = ws_bus.dest;
    assign wb.data = ws_bus.final_result;
    assign wb.pc   = ws_bus.pc;

endmodule

`default_nettype wire

// ==== hdl/mem_stage.sv ====
`default_nettype none

module mem_stage (
    input  wire logic              clk,
    input  wire logic              reset,
    input  wire logic              es_to_ms_valid,
    input  var cpu_pkg::es_to_ms_t es_to_ms_bus,
    output logic                   ms_allowin,
    input  wire logic [31:0]       ram_rdata,
    input  wire logic              ws_allowin,
    output logic                   ms_to_ws_valid,
    output cpu_pkg::ms_to_ws_t     ms_to_ws_bus
);

    logic               ms_valid;
    cpu_pkg::es_to_ms_t ms_bus;
    logic               data_held;
    logic [31:0]        data_hold;
    logic [31:0]        load_data;

    assign ms_allowin     = !ms_valid || ws_allowin;
    assign ms_to_ws_valid = ms_valid;

    always_ff @(posedge clk) begin
        if (reset) begin
            ms_valid  <= 1'b0;
            data_held <= 1'b0;
        end else if (ms_allowin) begin
            ms_valid  <= es_to_ms_valid;
            data_held <= 1'b0;
        end else if (!data_held) begin
            data_held <= 1'b1;    // first stalled edge keeps the read data.
        end
    end

    always_ff @(posedge clk) begin
        if (es_to_ms_valid && ms_allowin) begin
            ms_bus <= es_to_ms_bus;
        end
        if (!ms_allowin && !data_held) begin
            data_hold <= ram_rdata;
        end
    end

    assign load_data = data_held ? data_hold : ram_rdata;

    assign ms_to_ws_bus.gr_we        = ms_bus.gr_we;
    assign ms_to_ws_bus.dest         = ms_bus.dest;
    assign ms_to_ws_bus.final_result = ms_bus.res_from_mem ? load_data : ms_bus.alu_result;
    assign ms_to_ws_bus.pc           = ms_bus.pc;

endmodule

`default_nettype wire

// ==== hdl/exe_stage.sv ====
`default_nettype none

module exe_stage (
    input  wire logic              clk,
    input  wire logic              reset,
    input  wire logic              in_valid,
    input  var cpu_pkg::ds_to_es_t in_bus,
    output logic                   in_allowin,
    input  wire logic              ms_allowin,
    output logic                   es_to_ms_valid,
    output cpu_pkg::es_to_ms_t     es_to_ms_bus,
    output logic                   ram_en,
    output logic [3:0]             ram_wen,
    output logic [31:0]            ram_addr,
    output logic [31:0]            ram_wdata
);

    logic               es_valid;
    logic               es_go;
    cpu_pkg::ds_to_es_t es_bus;
    logic [31:0]        alu_src1;
    logic [31:0]        alu_src2;
    logic [31:0]        alu_result;

    assign in_allowin     = !es_valid || ms_allowin;
    assign es_to_ms_valid = es_valid;
    assign es_go          = es_to_ms_valid && ms_allowin;    // operation leaves this edge.

    always_ff @(posedge clk) begin
        if (reset) begin
            es_valid <= 1'b0;
        end else if (in_allowin) begin
            es_valid <= in_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (in_valid && in_allowin) begin
            es_bus <= in_bus;
        end
    end

    assign alu_src1 = es_bus.src1_is_sa ? {27'b0, es_bus.imm[10:6]} :
                      es_bus.src1_is_pc ? es_bus.pc :
                                          es_bus.rs_value;
    assign alu_src2 = es_bus.src2_is_imm ? {{16{es_bus.imm[15]}}, es_bus.imm} :
                      es_bus.src2_is_8   ? 32'd8 :
                                           es_bus.rt_value;

    alu u_alu (
        .alu_op (es_bus.alu_op),
        .src1   (alu_src1),
        .src2   (alu_src2),
        .result (alu_result)
    );

    assign es_to_ms_bus.res_from_mem = es_bus.load_op;
    assign es_to_ms_bus.gr_we        = es_bus.gr_we;
    assign es_to_ms_bus.dest         = es_bus.dest;
    assign es_to_ms_bus.alu_result   = alu_result;
    assign es_to_ms_bus.pc           = es_bus.pc;

    // the access is issued on the same edge that hands the operation to memory.
    assign ram_en    = es_go && (es_bus.load_op || es_bus.mem_we);
    assign ram_wen   = {4{es_go && es_bus.mem_we}};
    assign ram_addr  = alu_result;
    assign ram_wdata = es_bus.rt_value;

endmodule

`default_nettype wire

// ==== hdl/data_ram.sv ====
`default_nettype none

module data_ram (
    input  wire logic        clk,
    input  wire logic        en,
    input  wire logic [3:0]  wen,
    input  wire logic [31:0] addr,
    input  wire logic [31:0] wdata,
    output logic [31:0]      rdata
);

    logic [31:0]                     mem [cpu_pkg::DATA_RAM_WORDS];
    logic [cpu_pkg::DATA_RAM_AW-1:0] idx;

    assign idx = addr[cpu_pkg::DATA_RAM_AW+1:2];    // upper address bits wrap.

    always_ff @(posedge clk) begin
        for (int lane = 0; lane < 4; lane++) begin
            if (wen[lane]) begin
                mem[idx][lane*8 +: 8] <= wdata[lane*8 +: 8];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (en) begin
            rdata <= mem[idx];    // a same-edge write is seen on the next read.
        end
    end

endmodule

`default_nettype wire

// ==== hdl/alu.sv ====
`default_nettype none

module alu (
    input  var cpu_pkg::alu_op_t alu_op,
    input  wire logic [31:0]     src1,
    input  wire logic [31:0]     src2,
    output logic [31:0]          result
);

    logic [4:0] shamt;

    assign shamt = src1[4:0];    // shifts use only the low five bits.

    always_comb begin
        case (alu_op)
            cpu_pkg::ADD: begin
                result = src1 + src2;
            end
            cpu_pkg::SUB: begin
                result = src1 - src2;
            end
            cpu_pkg::SLT: begin
                result = {31'b0, $signed(src1) < $signed(src2)};
            end
            cpu_pkg::SLTU: begin
                result = {31'b0, src1 < src2};
            end
            cpu_pkg::AND: begin
                result = src1 & src2;
            end
            cpu_pkg::OR: begin
                result = src1 | src2;
            end
            cpu_pkg::XOR: begin
                result = src1 ^ src2;
            end
            cpu_pkg::NOR: begin
                result = ~(src1 | src2);
            end
            cpu_pkg::SLL: begin
                result = src2 << shamt;
            end
            cpu_pkg::SRL: begin
                result = src2 >> shamt;
            end
            cpu_pkg::SRA: begin
                result = $unsigned($signed(src2) >>> shamt);
            end
            cpu_pkg::LUI: begin
                result = {src2[15:0], 16'b0};
            end
            default: begin
                result = 32'b0;    // unused encodings give zero.
            end
        endcase
    end

endmodule

`default_nettype wire

// ==== hdl/cpu_pkg.sv ====
`default_nettype none

package cpu_pkg;

    localparam int DATA_RAM_WORDS = 256;
    localparam int DATA_RAM_AW    = 8;    // word index taken from address bits 9:2.

    typedef enum logic [3:0] {
        ADD  = 4'd0,
        SUB  = 4'd1,
        SLT  = 4'd2,
        SLTU = 4'd3,
        AND  = 4'd4,
        OR   = 4'd5,
        XOR  = 4'd6,
        NOR  = 4'd7,
        SLL  = 4'd8,
        SRL  = 4'd9,
        SRA  = 4'd10,
        LUI  = 4'd11
    } alu_op_t;

    // decoded operation handed to the execute stage.
    typedef struct packed {
        alu_op_t     alu_op;
        logic        load_op;
        logic        src1_is_sa;
        logic        src1_is_pc;
        logic        src2_is_imm;
        logic        src2_is_8;
        logic        gr_we;
        logic        mem_we;
        logic [4:0]  dest;
        logic [15:0] imm;         // sa lives in bits 10:6.
        logic [31:0] rs_value;
        logic [31:0] rt_value;
        logic [31:0] pc;
    } ds_to_es_t;

    typedef struct packed {
        logic        res_from_mem;
        logic        gr_we;
        logic [4:0]  dest;
        logic [31:0] alu_result;
        logic [31:0] pc;
    } es_to_ms_t;

    typedef struct packed {
        logic        gr_we;
        logic [4:0]  dest;
        logic [31:0] final_result;
        logic [31:0] pc;
    } ms_to_ws_t;

    // one retired operation as seen at the top output.
    typedef struct packed {
        logic        we;
        logic [4:0]  dest;
        logic [31:0] data;
        logic [31:0] pc;
    } wb_rec_t;

endpackage

`default_nettype wire
